//--- lc4_pkg.sv
`default_nettype none
package lc4_pkg;

    typedef logic [15:0] word_t;     // data, pc and instruction
    typedef logic [2:0]  reg_sel_t;
    typedef logic [2:0]  nzp_t;      // {n, z, p}

    localparam nzp_t NZP_N = 3'b100;
    localparam nzp_t NZP_Z = 3'b010;
    localparam nzp_t NZP_P = 3'b001;

    // opcode field, insn[15:12]
    typedef enum logic [3:0] {
        OP_BR    = 4'b0000,
        OP_ARITH = 4'b0001,
        OP_AND   = 4'b0101,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_CONST = 4'b1001
    } lc4_op_e;

    // sub-op in insn[5:3]
    // AND uses 000 as well, but under its own opcode
    typedef logic [2:0] alu_sub_e;
    localparam alu_sub_e ALU_ADD = 3'b000;
    localparam alu_sub_e ALU_SUB = 3'b010;
    localparam alu_sub_e ALU_AND = 3'b000;

    localparam int    NUM_REGS = 8;
    localparam word_t NOP_INSN = 16'h0000;   // BR with no condition bits

endpackage
`default_nettype wire

//--- lc4_decoder.sv
`timescale 1ns/10ps
`default_nettype none
module lc4_decoder (
    input  wire lc4_pkg::word_t i_insn,
    output lc4_pkg::reg_sel_t   o_rs_sel,
    output lc4_pkg::reg_sel_t   o_rt_sel,
    output lc4_pkg::reg_sel_t   o_rd_sel,
    output logic                o_rs_re,
    output logic                o_rt_re,
    output logic                o_rd_we,
    output logic                o_nzp_we,
    output logic                o_is_load,
    output logic                o_is_store,
    output logic                o_is_branch
);
    import lc4_pkg::*;

    lc4_op_e  op;
    alu_sub_e sub;

    assign op  = lc4_op_e'(i_insn[15:12]);
    assign sub = i_insn[5:3];

    always_comb begin
        o_rs_sel    = i_insn[8:6];
        o_rt_sel    = i_insn[2:0];
        o_rd_sel    = i_insn[11:9];
        o_rs_re     = 1'b0;
        o_rt_re     = 1'b0;
        o_rd_we     = 1'b0;
        o_nzp_we    = 1'b0;
        o_is_load   = 1'b0;
        o_is_store  = 1'b0;
        o_is_branch = 1'b0;
        case (op)
            OP_BR: begin
                o_is_branch = |i_insn[11:9];   // empty condition is the nop
            end
            OP_ARITH: begin
                if (i_insn[5]) begin           // add immediate
                    o_rs_re  = 1'b1;
                    o_rd_we  = 1'b1;
                    o_nzp_we = 1'b1;
                end else if (sub == ALU_ADD || sub == ALU_SUB) begin
                    o_rs_re  = 1'b1;
                    o_rt_re  = 1'b1;
                    o_rd_we  = 1'b1;
                    o_nzp_we = 1'b1;
                end
            end
            OP_AND: begin
                if (sub == ALU_AND) begin
                    o_rs_re  = 1'b1;
                    o_rt_re  = 1'b1;
                    o_rd_we  = 1'b1;
                    o_nzp_we = 1'b1;
                end
            end
            OP_LDR: begin
                o_rs_re   = 1'b1;
                o_rd_we   = 1'b1;
                o_nzp_we  = 1'b1;
                o_is_load = 1'b1;
            end
            OP_STR: begin
                o_rt_sel   = i_insn[11:9];     // store data sits in the rd field
                o_rs_re    = 1'b1;
                o_rt_re    = 1'b1;
                o_is_store = 1'b1;
            end
            OP_CONST: begin
                o_rd_we  = 1'b1;
                o_nzp_we = 1'b1;
            end
            default: begin
                o_rd_we = 1'b0;                // unsupported ops retire as no-ops
            end
        endcase
    end

endmodule
`default_nettype wire

//--- lc4_regfile.sv
`timescale 1ns/10ps
`default_nettype none
module lc4_regfile (
    input  wire                   gwe,
    input  wire                   i_rst,
    input  wire lc4_pkg::reg_sel_t i_rs_sel,
    input  wire lc4_pkg::reg_sel_t i_rt_sel,
    input  wire lc4_pkg::reg_sel_t i_rd_sel,
    input  wire                   i_rd_we,
    input  wire lc4_pkg::word_t   i_rd_data,
    output lc4_pkg::word_t        o_rs_data,
    output lc4_pkg::word_t        o_rt_data
);
    import lc4_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_we) begin
            regs[i_rd_sel] <= i_rd_data;
        end
    end

    // write in W shows up on the D reads of the same cycle
    assign o_rs_data = (i_rd_we && i_rd_sel == i_rs_sel) ? i_rd_data : regs[i_rs_sel];
    assign o_rt_data = (i_rd_we && i_rd_sel == i_rt_sel) ? i_rd_data : regs[i_rt_sel];

endmodule
`default_nettype wire

//--- lc4_alu.sv
`timescale 1ns/10ps
`default_nettype none
module lc4_alu (
    input  wire lc4_pkg::word_t i_insn,
    input  wire lc4_pkg::word_t i_pc,
    input  wire lc4_pkg::word_t i_rs_data,
    input  wire lc4_pkg::word_t i_rt_data,
    output lc4_pkg::word_t      o_result
);
    import lc4_pkg::*;

    lc4_op_e  op;
    alu_sub_e sub;
    word_t    imm5;
    word_t    imm6;
    word_t    imm9;

    assign op   = lc4_op_e'(i_insn[15:12]);
    assign sub  = i_insn[5:3];
    assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};
    assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};
    assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};

    always_comb begin
        o_result = '0;
        case (op)
            OP_ARITH: begin
                if (i_insn[5]) begin
                    o_result = i_rs_data + imm5;
                end else if (sub == ALU_SUB) begin
                    o_result = i_rs_data - i_rt_data;
                end else begin
                    o_result = i_rs_data + i_rt_data;
                end
            end
            OP_AND:   o_result = i_rs_data & i_rt_data;
            OP_CONST: o_result = imm9;
            OP_LDR,
            OP_STR:   o_result = i_rs_data + imm6;     // effective address
            OP_BR:    o_result = i_pc + 16'd1 + imm9;  // branch target
            default:  o_result = '0;
        endcase
    end

endmodule
`default_nettype wire

//--- lc4_hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none
module lc4_hazard_unit (
    input  wire                    i_x_is_load,
    input  wire lc4_pkg::reg_sel_t i_x_rd_sel,
    input  wire lc4_pkg::reg_sel_t i_d_rs_sel,
    input  wire lc4_pkg::reg_sel_t i_d_rt_sel,
    input  wire                    i_d_rs_re,
    input  wire                    i_d_rt_re,
    input  wire                    i_d_is_store,
    input  wire                    i_d_is_branch,
    input  wire                    i_x_branch_taken,
    output logic                   o_stall,
    output logic                   o_flush
);

    logic rs_dep;
    logic rt_dep;
    logic load_use;

    assign rs_dep = i_d_rs_re && (i_d_rs_sel == i_x_rd_sel);
    // store data is picked up by the WM bypass, so no bubble for it
    assign rt_dep = i_d_rt_re && (i_d_rt_sel == i_x_rd_sel) && !i_d_is_store;

    // a branch behind a load waits for the load's nzp
    assign load_use = i_x_is_load && (rs_dep || rt_dep || i_d_is_branch);

    assign o_flush = i_x_branch_taken;
    assign o_stall = load_use && !i_x_branch_taken;   // flushed slots need no stall

endmodule
`default_nettype wire

//--- lc4_bypass_unit.sv
`timescale 1ns/10ps
`default_nettype none
module lc4_bypass_unit (
    input  wire lc4_pkg::reg_sel_t i_x_rs_sel,
    input  wire lc4_pkg::reg_sel_t i_x_rt_sel,
    input  wire                    i_x_rs_re,
    input  wire                    i_x_rt_re,
    input  wire lc4_pkg::word_t    i_x_rs_rf,
    input  wire lc4_pkg::word_t    i_x_rt_rf,
    input  wire lc4_pkg::reg_sel_t i_m_rd_sel,
    input  wire                    i_m_rd_we,
    input  wire lc4_pkg::word_t    i_m_result,
    input  wire lc4_pkg::reg_sel_t i_w_rd_sel,
    input  wire                    i_w_rd_we,
    input  wire lc4_pkg::word_t    i_w_data,
    input  wire lc4_pkg::reg_sel_t i_m_rt_sel,
    input  wire                    i_m_is_store,
    input  wire lc4_pkg::word_t    i_m_store_rf,
    output lc4_pkg::word_t         o_x_rs,
    output lc4_pkg::word_t         o_x_rt,
    output lc4_pkg::word_t         o_m_store_data
);

    logic mx_rs;
    logic mx_rt;
    logic wx_rs;
    logic wx_rt;
    logic wm_rt;

    assign mx_rs = i_x_rs_re && i_m_rd_we && (i_m_rd_sel == i_x_rs_sel);
    assign mx_rt = i_x_rt_re && i_m_rd_we && (i_m_rd_sel == i_x_rt_sel);
    assign wx_rs = i_x_rs_re && i_w_rd_we && (i_w_rd_sel == i_x_rs_sel);
    assign wx_rt = i_x_rt_re && i_w_rd_we && (i_w_rd_sel == i_x_rt_sel);

    // M is younger than W, so it wins
    assign o_x_rs = mx_rs ? i_m_result : (wx_rs ? i_w_data : i_x_rs_rf);
    assign o_x_rt = mx_rt ? i_m_result : (wx_rt ? i_w_data : i_x_rt_rf);

    // load in W feeding a store in M
    assign wm_rt          = i_m_is_store && i_w_rd_we && (i_w_rd_sel == i_m_rt_sel);
    assign o_m_store_data = wm_rt ? i_w_data : i_m_store_rf;

endmodule
`default_nettype wire

//--- lc4_pipe_top.sv
`timescale 1ns/10ps
`default_nettype none
module lc4_pipe_top #(
    parameter lc4_pkg::word_t P_RESET_PC = 16'h8200
) (
    input  wire                  gwe,
    input  wire                  i_rst,
    output lc4_pkg::word_t       o_imem_addr,
    input  wire lc4_pkg::word_t  i_imem_insn,
    output lc4_pkg::word_t       o_dmem_addr,
    input  wire lc4_pkg::word_t  i_dmem_rdata,
    output lc4_pkg::word_t       o_dmem_wdata,
    output logic                 o_dmem_we,
    output logic                 o_wb_valid,
    output lc4_pkg::word_t       o_wb_pc,
    output lc4_pkg::word_t       o_wb_insn,
    output logic                 o_wb_rf_we,
    output lc4_pkg::reg_sel_t    o_wb_rsel,
    output lc4_pkg::word_t       o_wb_rdata,
    output logic                 o_wb_nzp_we,
    output lc4_pkg::nzp_t        o_wb_nzp
);
    import lc4_pkg::*;

    word_t    f_pc;
    word_t    next_pc;
    logic     stall;
    logic     flush;
    logic     x_taken;

    word_t    d_insn;
    word_t    d_pc;
    logic     d_valid;
    reg_sel_t dec_rs_sel, dec_rt_sel, dec_rd_sel;
    logic     dec_rs_re, dec_rt_re, dec_rd_we, dec_nzp_we;
    logic     dec_is_load, dec_is_store, dec_is_branch;
    word_t    rf_rs_data;
    word_t    rf_rt_data;

    word_t    x_insn;
    word_t    x_pc;
    logic     x_valid;
    reg_sel_t x_rs_sel, x_rt_sel, x_rd_sel;
    logic     x_rs_re, x_rt_re, x_rd_we, x_nzp_we;
    logic     x_is_load, x_is_store, x_is_branch;
    word_t    x_rs_rf;
    word_t    x_rt_rf;
    word_t    x_rs;
    word_t    x_rt;
    word_t    alu_result;

    word_t    m_insn;
    word_t    m_pc;
    logic     m_valid;
    reg_sel_t m_rd_sel, m_rt_sel;
    logic     m_rd_we, m_nzp_we, m_is_load, m_is_store;
    word_t    m_result;
    word_t    m_store_rf;
    word_t    m_store_data;
    word_t    m_wdata;       // what M will write back
    nzp_t     m_nzp;

    word_t    w_insn;
    word_t    w_pc;
    logic     w_valid;
    reg_sel_t w_rd_sel;
    logic     w_rd_we, w_nzp_we, w_is_load;
    word_t    w_result;
    word_t    w_load_data;
    word_t    w_data;
    nzp_t     w_nzp;

    nzp_t     nzp_reg;
    nzp_t     nzp_used;

    // fetch
    assign o_imem_addr = f_pc;
    assign next_pc     = x_taken ? alu_result : (stall ? f_pc : f_pc + 16'd1);

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            f_pc <= P_RESET_PC;
        end else begin
            f_pc <= next_pc;
        end
    end

    // F -> D, held on a load-use stall
    always_ff @(posedge gwe) begin
        if (i_rst || flush) begin
            d_insn  <= NOP_INSN;
            d_valid <= 1'b0;
        end else if (!stall) begin
            d_insn  <= i_imem_insn;
            d_valid <= 1'b1;
        end
    end

    always_ff @(posedge gwe) begin
        if (!stall) begin
            d_pc <= f_pc;
        end
    end

    lc4_decoder u_decoder (
        .i_insn      (d_insn),
        .o_rs_sel    (dec_rs_sel),
        .o_rt_sel    (dec_rt_sel),
        .o_rd_sel    (dec_rd_sel),
        .o_rs_re     (dec_rs_re),
        .o_rt_re     (dec_rt_re),
        .o_rd_we     (dec_rd_we),
        .o_nzp_we    (dec_nzp_we),
        .o_is_load   (dec_is_load),
        .o_is_store  (dec_is_store),
        .o_is_branch (dec_is_branch)
    );

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_rst     (i_rst),
        .i_rs_sel  (dec_rs_sel),
        .i_rt_sel  (dec_rt_sel),
        .i_rd_sel  (w_rd_sel),
        .i_rd_we   (w_rd_we),
        .i_rd_data (w_data),
        .o_rs_data (rf_rs_data),
        .o_rt_data (rf_rt_data)
    );

    lc4_hazard_unit u_hazard (
        .i_x_is_load      (x_is_load),
        .i_x_rd_sel       (x_rd_sel),
        .i_d_rs_sel       (dec_rs_sel),
        .i_d_rt_sel       (dec_rt_sel),
        .i_d_rs_re        (dec_rs_re),
        .i_d_rt_re        (dec_rt_re),
        .i_d_is_store     (dec_is_store),
        .i_d_is_branch    (dec_is_branch),
        .i_x_branch_taken (x_taken),
        .o_stall          (stall),
        .o_flush          (flush)
    );

    // D -> X, a stall or flush drops a bubble in
    always_ff @(posedge gwe) begin
        if (i_rst || flush || stall) begin
            x_insn      <= NOP_INSN;
            x_valid     <= 1'b0;
            x_rs_re     <= 1'b0;
            x_rt_re     <= 1'b0;
            x_rd_we     <= 1'b0;
            x_nzp_we    <= 1'b0;
            x_is_load   <= 1'b0;
            x_is_store  <= 1'b0;
            x_is_branch <= 1'b0;
        end else begin
            x_insn      <= d_insn;
            x_valid     <= d_valid;
            x_rs_re     <= dec_rs_re;
            x_rt_re     <= dec_rt_re;
            x_rd_we     <= dec_rd_we;
            x_nzp_we    <= dec_nzp_we;
            x_is_load   <= dec_is_load;
            x_is_store  <= dec_is_store;
            x_is_branch <= dec_is_branch;
        end
    end

    always_ff @(posedge gwe) begin
        x_pc     <= d_pc;
        x_rs_sel <= dec_rs_sel;
        x_rt_sel <= dec_rt_sel;
        x_rd_sel <= dec_rd_sel;
        x_rs_rf  <= rf_rs_data;
        x_rt_rf  <= rf_rt_data;
    end

    lc4_bypass_unit u_bypass (
        .i_x_rs_sel     (x_rs_sel),
        .i_x_rt_sel     (x_rt_sel),
        .i_x_rs_re      (x_rs_re),
        .i_x_rt_re      (x_rt_re),
        .i_x_rs_rf      (x_rs_rf),
        .i_x_rt_rf      (x_rt_rf),
        .i_m_rd_sel     (m_rd_sel),
        .i_m_rd_we      (m_rd_we),
        .i_m_result     (m_result),
        .i_w_rd_sel     (w_rd_sel),
        .i_w_rd_we      (w_rd_we),
        .i_w_data       (w_data),
        .i_m_rt_sel     (m_rt_sel),
        .i_m_is_store   (m_is_store),
        .i_m_store_rf   (m_store_rf),
        .o_x_rs         (x_rs),
        .o_x_rt         (x_rt),
        .o_m_store_data (m_store_data)
    );

    lc4_alu u_alu (
        .i_insn    (x_insn),
        .i_pc      (x_pc),
        .i_rs_data (x_rs),
        .i_rt_data (x_rt),
        .o_result  (alu_result)
    );

    // branch sees the nzp being written by M this cycle
    assign nzp_used = m_nzp_we ? m_nzp : nzp_reg;
    assign x_taken  = x_is_branch && |(nzp_used & x_insn[11:9]);

    // X -> M
    always_ff @(posedge gwe) begin
        if (i_rst) begin
            m_insn     <= NOP_INSN;
            m_valid    <= 1'b0;
            m_rd_we    <= 1'b0;
            m_nzp_we   <= 1'b0;
            m_is_load  <= 1'b0;
            m_is_store <= 1'b0;
        end else begin
            m_insn     <= x_insn;
            m_valid    <= x_valid;
            m_rd_we    <= x_rd_we;
            m_nzp_we   <= x_nzp_we;
            m_is_load  <= x_is_load;
            m_is_store <= x_is_store;
        end
    end

    always_ff @(posedge gwe) begin
        m_pc       <= x_pc;
        m_rd_sel   <= x_rd_sel;
        m_rt_sel   <= x_rt_sel;
        m_result   <= alu_result;
        m_store_rf <= x_rt;
    end

    assign o_dmem_addr  = m_result;
    assign o_dmem_we    = m_is_store;
    assign o_dmem_wdata = m_store_data;

    assign m_wdata = m_is_load ? i_dmem_rdata : m_result;

    always_comb begin
        if ($signed(m_wdata) < 0) begin
            m_nzp = NZP_N;
        end else if (m_wdata == '0) begin
            m_nzp = NZP_Z;
        end else begin
            m_nzp = NZP_P;
        end
    end

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            nzp_reg <= NZP_Z;               // matches the cleared register file
        end else if (m_nzp_we) begin
            nzp_reg <= m_nzp;
        end
    end

    // M -> W
    always_ff @(posedge gwe) begin
        if (i_rst) begin
            w_insn    <= NOP_INSN;
            w_valid   <= 1'b0;
            w_rd_we   <= 1'b0;
            w_nzp_we  <= 1'b0;
            w_is_load <= 1'b0;
        end else begin
            w_insn    <= m_insn;
            w_valid   <= m_valid;
            w_rd_we   <= m_rd_we;
            w_nzp_we  <= m_nzp_we;
            w_is_load <= m_is_load;
        end
    end

    always_ff @(posedge gwe) begin
        w_pc        <= m_pc;
        w_rd_sel    <= m_rd_sel;
        w_result    <= m_result;
        w_load_data <= i_dmem_rdata;
        w_nzp       <= m_nzp;
    end

    assign w_data = w_is_load ? w_load_data : w_result;

    // trace port
    assign o_wb_valid  = w_valid;
    assign o_wb_pc     = w_pc;
    assign o_wb_insn   = w_insn;
    assign o_wb_rf_we  = w_rd_we;
    assign o_wb_rsel   = w_rd_sel;
    assign o_wb_rdata  = w_data;
    assign o_wb_nzp_we = w_nzp_we;
    assign o_wb_nzp    = w_nzp;

endmodule
`default_nettype wire

//--- lc4_pipe_top_asserts.sv
`timescale 1ns/10ps
`default_nettype none
module lc4_pipe_top_asserts (
    input wire       gwe,
    input wire       i_rst,
    input wire       i_dmem_we,
    input wire       i_wb_valid,
    input wire       i_wb_rf_we,
    input wire       i_wb_nzp_we,
    input wire [2:0] i_wb_nzp
);

    // no memory write once reset has been held for a cycle
    a_no_store_in_reset: assert property (@(posedge gwe) (i_rst && $past(i_rst)) |-> !i_dmem_we)
        else $error("data memory write enable high during reset");

    a_rf_we_valid: assert property (@(posedge gwe) disable iff (i_rst) i_wb_rf_we |-> i_wb_valid)
        else $error("register write retired without a valid instruction");

    a_nzp_onehot: assert property (@(posedge gwe) disable iff (i_rst)
        i_wb_nzp_we |-> $onehot(i_wb_nzp))
        else $error("nzp written with a value that is not one-hot");

endmodule

bind lc4_pipe_top lc4_pipe_top_asserts u_asserts (
    .gwe         (gwe),
    .i_rst       (i_rst),
    .i_dmem_we   (o_dmem_we),
    .i_wb_valid  (o_wb_valid),
    .i_wb_rf_we  (o_wb_rf_we),
    .i_wb_nzp_we (o_wb_nzp_we),
    .i_wb_nzp    (o_wb_nzp)
);
`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none
module tb_clk_gen (
    output logic o_gwe,
    output logic o_rst
);

    initial begin
        o_gwe = 1'b0;
        forever #4 o_gwe = ~o_gwe;    // 8 ns period
    end

    initial begin
        o_rst = 1'b1;
        repeat (10) @(posedge o_gwe);
        #1 o_rst = 1'b0;
    end

endmodule
`default_nettype wire

//--- tb_lc4_pipe_top.sv
`timescale 1ns/10ps
`default_nettype none
module tb_lc4_pipe_top;
    import lc4_pkg::*;

    localparam word_t RESET_PC = 16'h8200;

    logic gwe, gen_rst, tb_rst, rst;
    word_t imem_addr, imem_insn, dmem_addr, dmem_rdata, dmem_wdata;
    logic dmem_we, wb_valid, wb_rf_we, wb_nzp_we;
    word_t wb_pc, wb_insn, wb_rdata, rom_off;
    reg_sel_t wb_rsel;
    nzp_t wb_nzp;

    word_t imem [64];
    word_t dmem [256];
    int    prog_len;
    logic  collecting;
    logic [31:0] rng;
    int    cyc, wd_start, wd_limit;

    word_t got_pc[$], got_insn[$], got_data[$], got_st_addr[$], got_st_data[$];
    logic  got_we[$], got_nzp_we[$];
    reg_sel_t got_rsel[$];
    nzp_t  got_nzp[$];
    word_t exp_pc[$], exp_insn[$], exp_data[$], exp_st_addr[$], exp_st_data[$];
    logic  exp_we[$];
    reg_sel_t exp_rsel[$];
    nzp_t  exp_nzp[$];

    tb_clk_gen u_clk (.o_gwe(gwe), .o_rst(gen_rst));

    assign rst        = gen_rst | tb_rst;
    assign rom_off    = imem_addr - RESET_PC;
    assign imem_insn  = (rom_off < 16'd64) ? imem[rom_off[5:0]] : NOP_INSN;
    assign dmem_rdata = dmem[dmem_addr[7:0]];

    lc4_pipe_top uut (
        .gwe (gwe), .i_rst (rst),
        .o_imem_addr (imem_addr), .i_imem_insn (imem_insn),
        .o_dmem_addr (dmem_addr), .i_dmem_rdata (dmem_rdata),
        .o_dmem_wdata (dmem_wdata), .o_dmem_we (dmem_we),
        .o_wb_valid (wb_valid), .o_wb_pc (wb_pc), .o_wb_insn (wb_insn),
        .o_wb_rf_we (wb_rf_we), .o_wb_rsel (wb_rsel), .o_wb_rdata (wb_rdata),
        .o_wb_nzp_we (wb_nzp_we), .o_wb_nzp (wb_nzp)
    );

    initial begin
        for (int i = 0; i < 256; i++) begin
            dmem[i] <= word_t'(i * 317) ^ 16'hc3a5;    // fill depends on every address bit
        end
    end

    // data memory writes and store capture
    always @(posedge gwe) begin
        cyc <= cyc + 1;
        if (dmem_we) begin
            dmem[dmem_addr[7:0]] <= dmem_wdata;
            if (collecting) begin
                got_st_addr.push_back(dmem_addr);
                got_st_data.push_back(dmem_wdata);
            end
        end
    end

    // retirements sampled mid-cycle
    always @(negedge gwe) begin
        if (collecting && wb_valid) begin
            got_pc.push_back(wb_pc);
            got_insn.push_back(wb_insn);
            got_we.push_back(wb_rf_we);
            got_rsel.push_back(wb_rsel);
            got_data.push_back(wb_rdata);
            got_nzp_we.push_back(wb_nzp_we);
            got_nzp.push_back(wb_nzp);
        end
    end

    always @(posedge gwe) begin
        if (cyc - wd_start > wd_limit) begin
            $display("timeout, the program did not retire all instructions in time");
            $display("Test FAILED");
            $fatal(1);
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t enc_rr(input logic [3:0] op, input reg_sel_t d, input reg_sel_t s,
                                     input logic [2:0] sub, input reg_sel_t t);
        return {op, d, s, sub, t};
    endfunction

    function automatic word_t enc_ri(input logic [3:0] op, input reg_sel_t d, input reg_sel_t s,
                                     input logic [5:0] imm);
        return {op, d, s, imm};    // addi passes {1, imm5}
    endfunction

    function automatic word_t enc_i9(input logic [3:0] op, input logic [2:0] d,
                                     input logic [8:0] imm);
        return {op, d, imm};
    endfunction

    task automatic compare(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic put(input word_t insn);
        imem[prog_len] = insn;
        prog_len++;
    endtask

    task automatic clear_program();
        for (int i = 0; i < 64; i++) begin
            imem[i] = NOP_INSN;
        end
        prog_len = 0;
    endtask

    // ISA reference, walks the program in order
    task automatic run_model();
        word_t regs [8];
        word_t mem [256];
        word_t pc, insn, rs, rt, res, addr;
        nzp_t  cur;
        logic  we;
        int    steps;
        foreach (regs[i]) regs[i] = '0;
        foreach (mem[i]) mem[i] = dmem[i];
        cur   = NZP_Z;
        pc    = RESET_PC;
        steps = 0;
        while (pc - RESET_PC < word_t'(prog_len) && steps < 200) begin
            insn = imem[pc - RESET_PC];
            rs   = regs[insn[8:6]];
            rt   = regs[insn[2:0]];
            we   = 1'b0;
            res  = '0;
            exp_pc.push_back(pc);
            exp_insn.push_back(insn);
            pc = pc + 16'd1;
            case (insn[15:12])
                4'h1: begin
                    we = insn[5] || insn[5:3] == 3'b000 || insn[5:3] == 3'b010;
                    if (insn[5]) res = rs + {{11{insn[4]}}, insn[4:0]};
                    else if (insn[5:3] == 3'b010) res = rs - rt;
                    else res = rs + rt;
                end
                4'h5: begin
                    we  = insn[5:3] == 3'b000;
                    res = rs & rt;
                end
                4'h9: begin
                    we  = 1'b1;
                    res = {{7{insn[8]}}, insn[8:0]};
                end
                4'h6: begin
                    we   = 1'b1;
                    addr = rs + {{10{insn[5]}}, insn[5:0]};
                    res  = mem[addr[7:0]];
                end
                4'h7: begin
                    addr = rs + {{10{insn[5]}}, insn[5:0]};
                    mem[addr[7:0]] = regs[insn[11:9]];
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(regs[insn[11:9]]);
                end
                4'h0: if (|(insn[11:9] & cur)) pc = pc + {{7{insn[8]}}, insn[8:0]};
                default: we = 1'b0;
            endcase
            if (we) begin
                regs[insn[11:9]] = res;
                cur = res[15] ? NZP_N : (res == '0 ? NZP_Z : NZP_P);
            end
            exp_we.push_back(we);
            exp_rsel.push_back(insn[11:9]);
            exp_data.push_back(res);
            exp_nzp.push_back(cur);
            steps++;
        end
    endtask

    // reset, run the loaded program and compare every retirement
    task automatic run_program();
        @(posedge gwe);
        #1 tb_rst = 1'b1;
        collecting = 1'b0;
        wd_start = cyc;
        wd_limit = 64 * prog_len + 20;
        got_pc = {};
        got_insn = {};
        got_we = {};
        got_rsel = {};
        got_data = {};
        got_nzp_we = {};
        got_nzp = {};
        got_st_addr = {};
        got_st_data = {};
        exp_pc = {};
        exp_insn = {};
        exp_we = {};
        exp_rsel = {};
        exp_data = {};
        exp_nzp = {};
        exp_st_addr = {};
        exp_st_data = {};
        run_model();
        @(posedge gwe);                                   // synchronous reset lands here
        repeat (9) begin
            @(negedge gwe);
            compare("o_dmem_we", word_t'(dmem_we), 16'h0);
            compare("o_wb_valid", word_t'(wb_valid), 16'h0);
        end
        @(posedge gwe);
        #1 tb_rst = 1'b0;
        collecting = 1'b1;
        @(negedge gwe);
        compare("o_imem_addr", imem_addr, RESET_PC);
        while (got_pc.size() < exp_pc.size()) @(negedge gwe);
        collecting = 1'b0;
        foreach (exp_pc[i]) begin
            compare("o_wb_pc", got_pc[i], exp_pc[i]);
            compare("o_wb_insn", got_insn[i], exp_insn[i]);
            compare("o_wb_rf_we", word_t'(got_we[i]), word_t'(exp_we[i]));
            compare("o_wb_nzp_we", word_t'(got_nzp_we[i]), word_t'(exp_we[i]));
            if (exp_we[i]) begin
                compare("o_wb_rsel", word_t'(got_rsel[i]), word_t'(exp_rsel[i]));
                compare("o_wb_rdata", got_data[i], exp_data[i]);
                compare("o_wb_nzp", word_t'(got_nzp[i]), word_t'(exp_nzp[i]));
            end
        end
        compare("store count", word_t'(got_st_addr.size()), word_t'(exp_st_addr.size()));
        foreach (exp_st_addr[i]) begin
            compare("o_dmem_addr", got_st_addr[i], exp_st_addr[i]);
            compare("o_dmem_wdata", got_st_data[i], exp_st_data[i]);
        end
    endtask

    task automatic test_arith_chain();
        clear_program();
        rng = xorshift(rng);
        put(enc_i9(4'h9, 3'd1, rng[8:0]));                // const r1
        put(enc_ri(4'h1, 3'd2, 3'd1, {1'b1, rng[13:9]})); // addi r2, r1
        put(enc_rr(4'h1, 3'd3, 3'd2, 3'b000, 3'd1));      // add r3, r2, r1
        put(enc_rr(4'h1, 3'd4, 3'd1, 3'b010, 3'd3));      // sub r4, r1, r3
        put(enc_rr(4'h5, 3'd5, 3'd4, 3'b000, 3'd3));      // and r5, r4, r3
        put(enc_rr(4'h1, 3'd6, 3'd5, 3'b010, 3'd5));      // zero result
        run_program();
    endtask

    task automatic test_load_use();
        clear_program();
        rng = xorshift(rng);
        dmem[16] <= rng[15:0];
        put(enc_i9(4'h9, 3'd0, 9'd16));
        put(enc_ri(4'h6, 3'd1, 3'd0, 6'd0));              // ldr r1 random word
        put(enc_ri(4'h7, 3'd1, 3'd0, 6'd1));              // str r1 straight after the load
        put(enc_ri(4'h6, 3'd2, 3'd0, 6'd1));
        put(enc_rr(4'h1, 3'd3, 3'd2, 3'b000, 3'd1));      // uses the load result
        run_program();
    endtask

    task automatic test_store_bypass();
        clear_program();
        rng = xorshift(rng);
        put(enc_i9(4'h9, 3'd1, 9'd40));
        put(enc_i9(4'h9, 3'd2, rng[8:0]));
        put(enc_rr(4'h1, 3'd2, 3'd2, 3'b000, 3'd2));
        put(enc_ri(4'h7, 3'd2, 3'd1, 6'd0));              // store of the add above
        put(enc_ri(4'h6, 3'd3, 3'd1, 6'd0));
        run_program();
    endtask

    task automatic test_branches();
        clear_program();
        dmem[32] <= 16'h0000;
        put(enc_i9(4'h9, 3'd1, 9'd5));
        put(enc_i9(4'h0, 3'b001, 9'd2));                  // taken on the nzp still in M
        put(enc_i9(4'h9, 3'd2, 9'd1));
        put(enc_i9(4'h9, 3'd3, 9'd2));
        put(enc_i9(4'h9, 3'd2, 9'd0));
        put(enc_i9(4'h0, 3'b001, 9'd1));                  // not taken, register still says p
        put(enc_i9(4'h9, 3'd0, 9'd32));
        put(enc_ri(4'h6, 3'd4, 3'd0, 6'd0));
        put(enc_i9(4'h0, 3'b010, 9'd1));                  // taken behind a load
        put(enc_i9(4'h9, 3'd5, 9'd3));
        put(enc_ri(4'h6, 3'd6, 3'd0, 6'd0));
        put(enc_i9(4'h0, 3'b101, 9'd1));                  // not taken behind a load
        put(enc_i9(4'h9, 3'd7, 9'd4));
        run_program();
    endtask

    initial begin
        tb_rst     = 1'b0;
        collecting = 1'b0;
        rng        = 32'h9463_339e;
        cyc        = 0;
        wd_start   = 0;
        wd_limit   = 100;
        prog_len   = 0;
        @(negedge gen_rst);
        test_arith_chain();
        test_load_use();
        test_store_bypass();
        test_branches();
        $display("Test OK");
        $finish;
    end

endmodule
`default_nettype wire

//--- lc4_pipe_top.f
lc4_pkg.sv
lc4_decoder.sv
lc4_regfile.sv
lc4_alu.sv
lc4_hazard_unit.sv
lc4_bypass_unit.sv
lc4_pipe_top.sv
lc4_pipe_top_asserts.sv
tb_clk_gen.sv
tb_lc4_pipe_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_lc4_pipe_top
FILELIST  ?= lc4_pipe_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
